// File: sdio_pkg.sv
// sdio host command path shared definitions
// frame sizes, timeout limit, counter widths and controller states
`default_nettype none

package sdio_pkg;

	// divider
	localparam int div_cnt_width = 10; // width of the ratio (period - 1)

	// frame layout
	localparam int cmd_frame_len = 48; // command and short response
	localparam int cmd_index_width = 6;
	localparam int cmd_arg_width = 32;
	localparam int crc7_width = 7;

	// strobes to wait for a response start bit
	localparam int resp_timeout_ticks = 64;

	// counter types
	typedef logic [$clog2(cmd_frame_len + 1)-1:0] frame_cnt_t; // 0..48
	typedef logic [$clog2(resp_timeout_ticks)-1:0] timeout_cnt_t; // 0..63

	// command sequencer
	typedef enum logic [1:0]
	{
		ctrl_idle,
		ctrl_send,
		ctrl_wait_resp,
		ctrl_done
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: sdio_cmd_if.sv
// command request path, sequencer to transmitter
`timescale 1ns/1ps
`default_nettype none

interface sdio_cmd_if;

	logic cmd_start; // one clk, only while tx idle
	logic [sdio_pkg::cmd_index_width-1:0] cmd_index; // held until cmd_sent
	logic [sdio_pkg::cmd_arg_width-1:0] cmd_arg;
	logic cmd_sent; // one clk after the frame is out

	modport ctrl
	(
		output cmd_start, cmd_index, cmd_arg,
		input cmd_sent
	);

	modport tx
	(
		input cmd_start, cmd_index, cmd_arg,
		output cmd_sent
	);

endinterface

`default_nettype wire

// File: sdio_resp_if.sv
// response path, arm from the sequencer and results from the receiver
`timescale 1ns/1ps
`default_nettype none

interface sdio_resp_if;

	logic resp_arm; // start hunting for a start bit
	logic resp_valid; // one clk, fields below valid with it
	logic [sdio_pkg::cmd_index_width-1:0] resp_index;
	logic [sdio_pkg::cmd_arg_width-1:0] resp_arg;
	logic resp_crc_err; // crc7 mismatch or bad end bit
	logic resp_timeout; // no start bit in time

	// exactly one of resp_valid / resp_timeout per arm

	modport ctrl
	(
		output resp_arm,
		input resp_valid, resp_index, resp_arg, resp_crc_err, resp_timeout
	);

	modport rx
	(
		input resp_arm,
		output resp_valid, resp_index, resp_arg, resp_crc_err, resp_timeout
	);

endinterface

`default_nettype wire

// File: sdio_sck_generator.sv
// sdio clock generator, integer divide with shadowed ratio and enable
// ddr output stage plus sample / update strobes
`timescale 1ns/1ps
`default_nettype none

module sdio_sck_generator (
	input wire clk,
	input wire resetn,
	input wire en_sdio_clk, // run request, low stops the clock
	input wire [sdio_pkg::div_cnt_width-1:0] div_rate, // period - 1
	input wire div_cnt_en, // divider enable, shadowed
	output logic sdio_in_sample, // one clk after the rising-edge position
	output logic sdio_out_upd, // one clk after wrap
	output logic sdio_clk
);

	logic en_shadow; // enable as used by the counter
	logic [sdio_pkg::div_cnt_width-1:0] rate_shadow; // ratio as used by the counter
	logic [sdio_pkg::div_cnt_width-1:0] div_cnt;
	logic [sdio_pkg::div_cnt_width-1:0] half_rate; // last low count
	logic [sdio_pkg::div_cnt_width-1:0] rise_pos; // count where sdio_clk goes high
	logic clk_off;
	logic cnt_wrap;
	logic shadow_load;
	logic hi_phase_d; // value for the clk-high half
	logic lo_phase_d; // value for the clk-low half
	logic hi_q;
	logic lo_q;

	assign clk_off = ~en_sdio_clk | ~en_shadow;
	assign cnt_wrap = div_cnt == rate_shadow;
	assign shadow_load = clk_off | cnt_wrap; // period boundary or stopped

	assign half_rate = {1'b0, rate_shadow[sdio_pkg::div_cnt_width-1:1]};
	// odd period count: rise is one count later, half cycle fixed by lo phase
	assign rise_pos = half_rate + {{(sdio_pkg::div_cnt_width-1){1'b0}}, rate_shadow[0]};

	assign hi_phase_d = ~clk_off & (div_cnt > half_rate);
	// even ratio (odd period) gets the extra half cycle in the low half
	assign lo_phase_d = ~clk_off & ((div_cnt > half_rate) |
		((div_cnt == half_rate) & ~rate_shadow[0]));

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
			en_shadow <= 1'b0;
		else if (shadow_load)
			en_shadow <= div_cnt_en;
	end

	always_ff @(posedge clk)
	begin
		if (shadow_load)
			rate_shadow <= div_rate; // takes effect next period
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
			div_cnt <= '0;
		else if (shadow_load)
			div_cnt <= '0; // wrap, or held while stopped
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// ddr stage
	// each flop loads while the other one is on the pin, so no mux glitch
	always_ff @(negedge clk or negedge resetn)
	begin
		if (~resetn)
			hi_q <= 1'b0;
		else
			hi_q <= hi_phase_d; // shown from the next rising clk
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
			lo_q <= 1'b0;
		else
			lo_q <= lo_phase_d; // shown from the next falling clk
	end

	assign sdio_clk = clk ? hi_q : lo_q;

	// strobes
	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
		begin
			sdio_out_upd <= 1'b0;
			sdio_in_sample <= 1'b0;
		end
		else
		begin
			sdio_out_upd <= ~clk_off & cnt_wrap;
			sdio_in_sample <= ~clk_off & (div_cnt == rise_pos);
		end
	end

endmodule

`default_nettype wire

// File: sdio_crc7.sv
// serial crc7 for sdio, polynomial x^7 + x^3 + 1
`timescale 1ns/1ps
`default_nettype none

module sdio_crc7 (
	input wire clk,
	input wire resetn,
	input wire crc_clr, // frame start
	input wire crc_shift, // one per covered bit
	input wire crc_bit,
	output logic [sdio_pkg::crc7_width-1:0] crc
);

	logic fb;

	assign fb = crc_bit ^ crc[sdio_pkg::crc7_width-1];

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
			crc <= '0;
		else if (crc_clr)
			crc <= '0; // clear wins over shift
		else if (crc_shift)
			crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb}; // taps at x^3 and x^0
	end

endmodule

`default_nettype wire

// File: sdio_cmd_tx.sv
// command transmitter, shifts a 48-bit frame with crc7 out on update strobes
`timescale 1ns/1ps
`default_nettype none

module sdio_cmd_tx (
	input wire clk,
	input wire resetn,
	input wire sdio_out_upd,
	sdio_cmd_if.tx cmd,
	output logic sdio_cmd_o,
	output logic sdio_cmd_oe
);

	logic active; // frame loaded, not yet released
	sdio_pkg::frame_cnt_t bit_cnt; // bits still to drive
	logic [sdio_pkg::cmd_frame_len-1:0] shreg;
	logic [sdio_pkg::cmd_frame_len-1:0] sh_next;
	logic [sdio_pkg::crc7_width-1:0] crc;
	logic tx_bit;
	logic load;
	logic drive; // a bit goes out this strobe
	logic crc_slot; // next bit is the crc msb
	logic crc_shift;

	assign load = ~active & cmd.cmd_start;
	assign drive = active & sdio_out_upd & (bit_cnt != '0);
	assign crc_slot = bit_cnt == sdio_pkg::frame_cnt_t'(sdio_pkg::crc7_width + 1);
	assign crc_shift = drive & (bit_cnt > sdio_pkg::frame_cnt_t'(sdio_pkg::crc7_width + 1));

	// after 40 covered bits the crc and end bit replace the low byte
	always_comb
	begin
		tx_bit = shreg[sdio_pkg::cmd_frame_len-1];
		sh_next = {shreg[sdio_pkg::cmd_frame_len-2:0], 1'b0};
		if (crc_slot)
		begin
			tx_bit = crc[sdio_pkg::crc7_width-1];
			sh_next = {crc[sdio_pkg::crc7_width-2:0], 1'b1,
				{(sdio_pkg::cmd_frame_len - sdio_pkg::crc7_width){1'b0}}};
		end
	end

	sdio_crc7 crc_gen_i (
		.clk(clk),
		.resetn(resetn),
		.crc_clr(load),
		.crc_shift(crc_shift),
		.crc_bit(tx_bit),
		.crc(crc)
	);

	always_ff @(posedge clk)
	begin
		if (load) // start, host direction, index, arg, crc slot, end
			shreg <= {1'b0, 1'b1, cmd.cmd_index, cmd.cmd_arg,
				{sdio_pkg::crc7_width{1'b0}}, 1'b1};
		else if (drive)
			shreg <= sh_next;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
		begin
			active <= 1'b0;
			bit_cnt <= '0;
			sdio_cmd_o <= 1'b1; // line idles high
			sdio_cmd_oe <= 1'b0;
			cmd.cmd_sent <= 1'b0;
		end
		else
		begin
			cmd.cmd_sent <= 1'b0;
			if (load)
			begin
				active <= 1'b1;
				bit_cnt <= sdio_pkg::frame_cnt_t'(sdio_pkg::cmd_frame_len);
			end
			else if (drive)
			begin
				sdio_cmd_o <= tx_bit;
				sdio_cmd_oe <= 1'b1;
				bit_cnt <= bit_cnt - 1'b1;
			end
			else if (active & sdio_out_upd) // strobe after the end bit
			begin
				sdio_cmd_o <= 1'b1;
				sdio_cmd_oe <= 1'b0;
				active <= 1'b0;
				cmd.cmd_sent <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: sdio_resp_rx.sv
// response receiver, start bit hunt with timeout, 48-bit collect, crc7 check
`timescale 1ns/1ps
`default_nettype none

module sdio_resp_rx (
	input wire clk,
	input wire resetn,
	input wire sdio_in_sample,
	input wire sdio_cmd_i,
	sdio_resp_if.rx resp
);

	typedef enum logic [1:0]
	{
		rx_idle,
		rx_hunt, // armed, waiting for a zero
		rx_collect,
		rx_check // results on the interface for one clk
	} rx_state_t;

	rx_state_t state;
	sdio_pkg::timeout_cnt_t wait_cnt; // strobes without a start bit
	sdio_pkg::frame_cnt_t bit_cnt; // bits taken, start bit included
	logic [sdio_pkg::cmd_frame_len-1:0] shreg;
	logic [sdio_pkg::crc7_width-1:0] crc;
	logic start_seen;
	logic take_bit;
	logic crc_shift;

	assign start_seen = (state == rx_hunt) & sdio_in_sample & ~sdio_cmd_i;
	assign take_bit = start_seen | ((state == rx_collect) & sdio_in_sample);
	// crc covers start bit through argument, first 40 bits
	assign crc_shift = start_seen | ((state == rx_collect) & sdio_in_sample &
		(bit_cnt < sdio_pkg::frame_cnt_t'(sdio_pkg::cmd_frame_len - sdio_pkg::crc7_width - 1)));

	sdio_crc7 crc_chk_i (
		.clk(clk),
		.resetn(resetn),
		.crc_clr(resp.resp_arm),
		.crc_shift(crc_shift),
		.crc_bit(sdio_cmd_i),
		.crc(crc)
	);

	always_ff @(posedge clk)
	begin
		if (take_bit)
			shreg <= {shreg[sdio_pkg::cmd_frame_len-2:0], sdio_cmd_i}; // msb first
	end

	// field extraction, frame fully in shreg during rx_check
	assign resp.resp_valid = state == rx_check;
	assign resp.resp_index = shreg[sdio_pkg::cmd_frame_len-3 -: sdio_pkg::cmd_index_width];
	assign resp.resp_arg = shreg[sdio_pkg::crc7_width+1 +: sdio_pkg::cmd_arg_width];
	assign resp.resp_crc_err = (shreg[sdio_pkg::crc7_width:1] != crc) | ~shreg[0];

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
		begin
			state <= rx_idle;
			wait_cnt <= '0;
			bit_cnt <= '0;
			resp.resp_timeout <= 1'b0;
		end
		else
		begin
			resp.resp_timeout <= 1'b0;
			if (resp.resp_arm)
			begin
				state <= rx_hunt;
				wait_cnt <= '0;
			end
			else
			begin
				case (state)
					rx_hunt:
						if (start_seen)
						begin
							state <= rx_collect;
							bit_cnt <= sdio_pkg::frame_cnt_t'(1);
						end
						else if (sdio_in_sample)
						begin
							if (wait_cnt == sdio_pkg::timeout_cnt_t'(sdio_pkg::resp_timeout_ticks - 1))
							begin
								state <= rx_idle; // give up
								resp.resp_timeout <= 1'b1;
							end
							else
								wait_cnt <= wait_cnt + 1'b1;
						end
					rx_collect:
						if (sdio_in_sample)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == sdio_pkg::frame_cnt_t'(sdio_pkg::cmd_frame_len - 1))
								state <= rx_check; // last bit lands now
						end
					rx_check:
						state <= rx_idle;
					default:
						state <= rx_idle;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: sdio_cmd_ctrl.sv
// command sequencer, one command plus optional response, holds the results
`timescale 1ns/1ps
`default_nettype none

module sdio_cmd_ctrl (
	input wire clk,
	input wire resetn,
	input wire cmd_start, // ignored while busy
	input wire [sdio_pkg::cmd_index_width-1:0] cmd_index,
	input wire [sdio_pkg::cmd_arg_width-1:0] cmd_arg,
	input wire resp_expected,
	sdio_cmd_if.ctrl cmd,
	sdio_resp_if.ctrl resp,
	output logic busy,
	output logic cmd_done,
	output logic [sdio_pkg::cmd_index_width-1:0] resp_index_o,
	output logic [sdio_pkg::cmd_arg_width-1:0] resp_arg_o,
	output logic resp_crc_err_o,
	output logic resp_timeout_o
);

	sdio_pkg::ctrl_state_t state;
	logic resp_exp_q; // captured with the request
	logic accept;
	logic resp_take;

	assign accept = (state == sdio_pkg::ctrl_idle) & cmd_start;
	assign resp_take = (state == sdio_pkg::ctrl_wait_resp) & resp.resp_valid;

	assign busy = state != sdio_pkg::ctrl_idle;
	assign cmd_done = state == sdio_pkg::ctrl_done; // single clk

	// request and response payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cmd.cmd_index <= cmd_index; // stable until cmd_sent
			cmd.cmd_arg <= cmd_arg;
		end
		if (resp_take)
		begin
			resp_index_o <= resp.resp_index;
			resp_arg_o <= resp.resp_arg;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
		begin
			state <= sdio_pkg::ctrl_idle;
			resp_exp_q <= 1'b0;
			cmd.cmd_start <= 1'b0;
			resp.resp_arm <= 1'b0;
			resp_crc_err_o <= 1'b0;
			resp_timeout_o <= 1'b0;
		end
		else
		begin
			cmd.cmd_start <= 1'b0;
			resp.resp_arm <= 1'b0;
			case (state)
				sdio_pkg::ctrl_idle:
					if (accept)
					begin
						state <= sdio_pkg::ctrl_send;
						resp_exp_q <= resp_expected;
						cmd.cmd_start <= 1'b1;
						resp_crc_err_o <= 1'b0; // old flags dropped
						resp_timeout_o <= 1'b0;
					end
				sdio_pkg::ctrl_send:
					if (cmd.cmd_sent)
					begin
						if (resp_exp_q)
						begin
							state <= sdio_pkg::ctrl_wait_resp;
							resp.resp_arm <= 1'b1;
						end
						else
							state <= sdio_pkg::ctrl_done;
					end
				sdio_pkg::ctrl_wait_resp:
					if (resp.resp_valid)
					begin
						resp_crc_err_o <= resp.resp_crc_err;
						state <= sdio_pkg::ctrl_done;
					end
					else if (resp.resp_timeout)
					begin
						resp_timeout_o <= 1'b1;
						state <= sdio_pkg::ctrl_done;
					end
				sdio_pkg::ctrl_done:
					state <= sdio_pkg::ctrl_idle;
				default:
					state <= sdio_pkg::ctrl_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sdio_host_top.sv
// sdio host command path top, clock generator, tx, rx and sequencer
`timescale 1ns/1ps
`default_nettype none

module sdio_host_top (
	input wire clk,
	input wire resetn,
	input wire en_sdio_clk,
	input wire [sdio_pkg::div_cnt_width-1:0] div_rate,
	input wire div_cnt_en,
	input wire cmd_start,
	input wire [sdio_pkg::cmd_index_width-1:0] cmd_index,
	input wire [sdio_pkg::cmd_arg_width-1:0] cmd_arg,
	input wire resp_expected,
	output wire busy,
	output wire cmd_done,
	output wire [sdio_pkg::cmd_index_width-1:0] resp_index,
	output wire [sdio_pkg::cmd_arg_width-1:0] resp_arg,
	output wire resp_crc_err,
	output wire resp_timeout,
	output wire sdio_clk,
	output wire sdio_cmd_o, // pad tristate lives on the board
	output wire sdio_cmd_oe,
	input wire sdio_cmd_i
);

	wire sdio_in_sample;
	wire sdio_out_upd;

	sdio_cmd_if cmd_bus ();
	sdio_resp_if resp_bus ();

	sdio_sck_generator sck_gen_i (
		.clk(clk),
		.resetn(resetn),
		.en_sdio_clk(en_sdio_clk),
		.div_rate(div_rate),
		.div_cnt_en(div_cnt_en),
		.sdio_in_sample(sdio_in_sample),
		.sdio_out_upd(sdio_out_upd),
		.sdio_clk(sdio_clk)
	);

	sdio_cmd_tx cmd_tx_i (
		.clk(clk),
		.resetn(resetn),
		.sdio_out_upd(sdio_out_upd),
		.cmd(cmd_bus.tx),
		.sdio_cmd_o(sdio_cmd_o),
		.sdio_cmd_oe(sdio_cmd_oe)
	);

	sdio_resp_rx resp_rx_i (
		.clk(clk),
		.resetn(resetn),
		.sdio_in_sample(sdio_in_sample),
		.sdio_cmd_i(sdio_cmd_i),
		.resp(resp_bus.rx)
	);

	sdio_cmd_ctrl cmd_ctrl_i (
		.clk(clk),
		.resetn(resetn),
		.cmd_start(cmd_start),
		.cmd_index(cmd_index),
		.cmd_arg(cmd_arg),
		.resp_expected(resp_expected),
		.cmd(cmd_bus.ctrl),
		.resp(resp_bus.ctrl),
		.busy(busy),
		.cmd_done(cmd_done),
		.resp_index_o(resp_index),
		.resp_arg_o(resp_arg),
		.resp_crc_err_o(resp_crc_err),
		.resp_timeout_o(resp_timeout)
	);

endmodule

`default_nettype wire

// File: tb_sdio_card.sv
// behavioral sdio card, captures host command frames on sdio_clk
// and answers them on the cmd line, optionally corrupted or not at all
`timescale 1ns/1ps
`default_nettype none

module tb_sdio_card (
	input wire sdio_clk,
	input wire sdio_cmd_o,
	input wire sdio_cmd_oe,
	input wire flip_crc, // answer with one crc bit inverted
	input wire silent, // never answer
	input wire [sdio_pkg::cmd_frame_len-1:0] resp_frame, // full answer incl. crc7
	output logic sdio_cmd_i,
	output logic [31:0] frame_cnt, // command frames seen
	output logic [sdio_pkg::cmd_frame_len-1:0] cmd_frame, // last command frame
	output logic replying // answer in progress
);

	logic [sdio_pkg::cmd_frame_len-1:0] shreg;
	logic [sdio_pkg::cmd_frame_len-1:0] tx_frame;
	int bit_cnt;
	event reply_ev;

	initial
	begin
		sdio_cmd_i = 1'b1; // line idles high
		frame_cnt = 0;
		cmd_frame = '0;
		replying = 1'b0;
		shreg = '0;
		bit_cnt = 0;
	end

	// host drives on update strobes, so rising sdio_clk sees a settled bit
	always @(posedge sdio_clk)
	begin
		if (sdio_cmd_oe === 1'b1)
		begin
			shreg = {shreg[sdio_pkg::cmd_frame_len-2:0], sdio_cmd_o}; // msb first
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == sdio_pkg::cmd_frame_len)
			begin
				cmd_frame = shreg;
				frame_cnt = frame_cnt + 1;
				bit_cnt = 0;
				if (silent !== 1'b1)
				begin
					tx_frame = resp_frame;
					if (flip_crc === 1'b1)
						tx_frame[1] = ~tx_frame[1]; // crc lsb
					replying = 1'b1;
					-> reply_ev;
				end
			end
		end
	end

	// answer two periods after the end bit, bits change on falling edges
	always
	begin
		@(reply_ev);
		repeat (2) @(posedge sdio_clk);
		for (int i = sdio_pkg::cmd_frame_len - 1; i >= 0; i--)
		begin
			@(negedge sdio_clk);
			sdio_cmd_i <= tx_frame[i];
		end
		@(negedge sdio_clk);
		sdio_cmd_i <= 1'b1; // back to idle
		replying = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb_sdio_host.sv
// testbench for the sdio host command path
// clock divider timing, command / response sequences against a behavioral card
`timescale 1ns/1ps
`default_nettype none

module tb_sdio_host;

	localparam int clk_half_ns = 20; // 40 ns clk
	localparam int cmd_wait_cycles = 4000; // limit for one command or one card answer

	logic clk;
	logic resetn;
	logic en_sdio_clk;
	logic [sdio_pkg::div_cnt_width-1:0] div_rate;
	logic div_cnt_en;
	logic cmd_start;
	logic [sdio_pkg::cmd_index_width-1:0] cmd_index;
	logic [sdio_pkg::cmd_arg_width-1:0] cmd_arg;
	logic resp_expected;
	wire busy;
	wire cmd_done;
	wire [sdio_pkg::cmd_index_width-1:0] resp_index;
	wire [sdio_pkg::cmd_arg_width-1:0] resp_arg;
	wire resp_crc_err;
	wire resp_timeout;
	wire sdio_clk;
	wire sdio_cmd_o;
	wire sdio_cmd_oe;
	wire sdio_cmd_i;

	// card controls and observations
	logic card_flip_crc;
	logic card_silent;
	logic [sdio_pkg::cmd_frame_len-1:0] card_resp_frame;
	wire [31:0] card_frame_cnt;
	wire [sdio_pkg::cmd_frame_len-1:0] card_cmd_frame;
	wire card_replying;

	// expected results of the running command
	logic [sdio_pkg::cmd_frame_len-1:0] exp_cmd_frame;
	logic [37:0] exp_fields; // index and argument
	logic exp_check_fields;
	logic exp_crc_err;
	logic exp_timeout;

	integer seed;
	int error_cnt = 0;
	int check_cnt = 0;
	int done_cnt = 0;

	// sdio_clk period bookkeeping
	int rise_cnt = 0;
	int upd_cnt = 0;
	int sample_cnt = 0;
	int upd_mark = 0;
	int sample_mark = 0;
	int period_upd = 0; // strobes in the last full period
	int period_sample = 0;
	time last_rise_t = 0;
	time period_ns = 0;

	sdio_host_top dut_i (
		.clk(clk),
		.resetn(resetn),
		.en_sdio_clk(en_sdio_clk),
		.div_rate(div_rate),
		.div_cnt_en(div_cnt_en),
		.cmd_start(cmd_start),
		.cmd_index(cmd_index),
		.cmd_arg(cmd_arg),
		.resp_expected(resp_expected),
		.busy(busy),
		.cmd_done(cmd_done),
		.resp_index(resp_index),
		.resp_arg(resp_arg),
		.resp_crc_err(resp_crc_err),
		.resp_timeout(resp_timeout),
		.sdio_clk(sdio_clk),
		.sdio_cmd_o(sdio_cmd_o),
		.sdio_cmd_oe(sdio_cmd_oe),
		.sdio_cmd_i(sdio_cmd_i)
	);

	tb_sdio_card card_i (
		.sdio_clk(sdio_clk),
		.sdio_cmd_o(sdio_cmd_o),
		.sdio_cmd_oe(sdio_cmd_oe),
		.flip_crc(card_flip_crc),
		.silent(card_silent),
		.resp_frame(card_resp_frame),
		.sdio_cmd_i(sdio_cmd_i),
		.frame_cnt(card_frame_cnt),
		.cmd_frame(card_cmd_frame),
		.replying(card_replying)
	);

	initial
		clk = 1'b0;

	always #clk_half_ns clk = ~clk;

	// crc7 over 40 bits msb first, poly x^7 + x^3 + 1
	function automatic logic [6:0] crc7_of(input logic [39:0] bits);
		logic [6:0] c;
		logic fb;
		c = '0;
		for (int i = 39; i >= 0; i--)
		begin
			fb = bits[i] ^ c[6];
			c = {c[5:0], 1'b0};
			if (fb)
				c = c ^ 7'h09;
		end
		return c;
	endfunction

	// start bit, direction, index, arg, crc7, end bit
	function automatic logic [47:0] build_frame(input logic dir, input logic [5:0] idx,
		input logic [31:0] arg);
		logic [39:0] head;
		head = {1'b0, dir, idx, arg};
		return {head, crc7_of(head), 1'b1};
	endfunction

	// card echoes the index and inverts the argument
	function automatic logic [37:0] expected_fields(input logic [5:0] idx,
		input logic [31:0] arg);
		return {idx, ~arg};
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		error_cnt++;
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic end_run;
		$display("checks %0d, errors %0d", check_cnt, error_cnt);
		if (error_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	task automatic give_up(input string what);
		sdio_pkg::ctrl_state_t st;
		st = dut_i.cmd_ctrl_i.state;
		error_cnt++;
		$display("Timeout at %0t ns: no %s, controller in %s", $time, what, st.name());
		end_run;
	endtask

	// strobes counted one clk late, so a rise never sees a half-updated count
	always @(posedge clk)
	begin
		if (sdio_out_upd_seen())
			upd_cnt <= upd_cnt + 1;
		if (dut_i.sdio_in_sample === 1'b1)
			sample_cnt <= sample_cnt + 1;
	end

	function automatic logic sdio_out_upd_seen();
		return dut_i.sdio_out_upd === 1'b1;
	endfunction

	always @(posedge sdio_clk)
	begin
		period_ns = $time - last_rise_t;
		last_rise_t = $time;
		period_upd = upd_cnt - upd_mark;
		period_sample = sample_cnt - sample_mark;
		upd_mark = upd_cnt;
		sample_mark = sample_cnt;
		rise_cnt = rise_cnt + 1; // last, fields above are complete
	end

	task automatic wait_sck_rises(input int n, input int ratio);
		int target;
		int cycles;
		target = rise_cnt + n;
		cycles = 0;
		while (rise_cnt < target && cycles < (n + 2) * (ratio + 1) * 4)
		begin
			@(posedge clk);
			cycles++;
		end
		if (rise_cnt < target)
			give_up("sdio_clk rising edge");
	endtask

	task automatic check_periods(input int ratio, input int skip, input int count);
		wait_sck_rises(skip, ratio); // let the shadow registers settle
		for (int k = 0; k < count; k++)
		begin
			wait_sck_rises(1, ratio);
			check_cnt++;
			if (period_ns != (ratio + 1) * 2 * clk_half_ns)
				report_mismatch("sdio_clk period in ns", period_ns, (ratio + 1) * 2 * clk_half_ns);
			if (period_upd != 1)
				report_mismatch("update strobes per period", period_upd, 1);
			if (period_sample != 1)
				report_mismatch("sample strobes per period", period_sample, 1);
		end
	endtask

	task automatic wait_done(input int start_cnt);
		int cycles;
		cycles = 0;
		while (done_cnt == start_cnt && cycles < cmd_wait_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		if (done_cnt == start_cnt)
			give_up("cmd_done");
	endtask

	task automatic wait_card_idle;
		int cycles;
		cycles = 0;
		while (card_replying === 1'b1 && cycles < cmd_wait_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		if (card_replying === 1'b1)
			give_up("end of the card answer");
	endtask

	// one command, optionally a second start while the first is running
	task automatic run_cmd(input logic [5:0] idx, input logic [31:0] arg, input logic resp_exp,
		input logic flip, input logic silent, input logic poke_busy);
		int start_cnt;
		int frames_before;
		exp_cmd_frame = build_frame(1'b1, idx, arg);
		exp_fields = expected_fields(idx, arg);
		exp_check_fields = resp_exp & ~silent;
		exp_crc_err = resp_exp & flip & ~silent;
		exp_timeout = resp_exp & silent;
		start_cnt = done_cnt;
		frames_before = card_frame_cnt;
		@(posedge clk);
		card_flip_crc <= flip;
		card_silent <= silent;
		card_resp_frame <= build_frame(1'b0, idx, ~arg); // card to host
		cmd_index <= idx;
		cmd_arg <= arg;
		resp_expected <= resp_exp;
		cmd_start <= 1'b1;
		@(posedge clk);
		cmd_start <= 1'b0;
		if (poke_busy)
		begin
			repeat (3) @(posedge clk);
			check_cnt++;
			if (busy !== 1'b1)
				report_mismatch("busy during a command", busy, 1);
			cmd_index <= ~idx; // must be dropped
			cmd_start <= 1'b1;
			@(posedge clk);
			cmd_start <= 1'b0;
		end
		wait_done(start_cnt);
		wait_card_idle;
		repeat (4) @(posedge clk);
		check_cnt++;
		if (card_frame_cnt != frames_before + 1)
			report_mismatch("frames seen by the card", card_frame_cnt - frames_before, 1);
		if (done_cnt != start_cnt + 1)
			report_mismatch("cmd_done pulses", done_cnt - start_cnt, 1);
	endtask

	// compare each finished command with the expected fields
	always @(posedge clk)
	begin
		if (resetn === 1'b1 && cmd_done === 1'b1)
		begin
			done_cnt++;
			check_cnt++;
			if (card_cmd_frame !== exp_cmd_frame) // crc7 included
				report_mismatch("command frame at the card", card_cmd_frame, exp_cmd_frame);
			if (resp_timeout !== exp_timeout)
				report_mismatch("resp_timeout", resp_timeout, exp_timeout);
			if (resp_crc_err !== exp_crc_err)
				report_mismatch("resp_crc_err", resp_crc_err, exp_crc_err);
			if (exp_check_fields)
			begin
				if (resp_index !== exp_fields[37:32])
					report_mismatch("resp_index", resp_index, exp_fields[37:32]);
				if (resp_arg !== exp_fields[31:0])
					report_mismatch("resp_arg", resp_arg, exp_fields[31:0]);
			end
		end
	end

	initial
	begin
		logic [5:0] idx;
		logic [31:0] arg;
		int rise_snap;
		int upd_snap;
		int sample_snap;
		seed = 32'hb897_27c8;
		resetn = 1'b0;
		en_sdio_clk = 1'b1;
		div_rate = 10'd3;
		div_cnt_en = 1'b1;
		cmd_start = 1'b0;
		cmd_index = '0;
		cmd_arg = '0;
		resp_expected = 1'b0;
		card_flip_crc = 1'b0;
		card_silent = 1'b0;
		card_resp_frame = '1;
		exp_cmd_frame = '0;
		exp_fields = '0;
		exp_check_fields = 1'b0;
		exp_crc_err = 1'b0;
		exp_timeout = 1'b0;
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check_cnt++;
		if (busy !== 1'b0 || cmd_done !== 1'b0 || sdio_cmd_oe !== 1'b0)
			report_mismatch("busy, cmd_done, oe after reset", {busy, cmd_done, sdio_cmd_oe}, 0);

		// divider periods
		check_periods(3, 2, 4);
		@(posedge clk);
		div_rate <= 10'd4;
		check_periods(4, 2, 4);
		@(posedge clk);
		div_rate <= 10'd3;
		wait_sck_rises(2, 4);

		// normal commands
		for (int n = 0; n < 10; n++)
		begin
			idx = $random(seed);
			arg = $random(seed);
			run_cmd(idx, arg, 1'b1, 1'b0, 1'b0, 1'b0);
		end
		idx = $random(seed);
		arg = $random(seed);
		run_cmd(idx, arg, 1'b1, 1'b1, 1'b0, 1'b0); // corrupted crc
		idx = $random(seed);
		arg = $random(seed);
		run_cmd(idx, arg, 1'b1, 1'b0, 1'b1, 1'b0); // silent card
		idx = $random(seed);
		arg = $random(seed);
		run_cmd(idx, arg, 1'b0, 1'b0, 1'b0, 1'b1); // no response, second start
		@(posedge clk);
		card_flip_crc <= 1'b0;
		card_silent <= 1'b0;

		// clock stop, then restart with a new ratio
		en_sdio_clk <= 1'b0;
		repeat (4) @(posedge clk);
		rise_snap = rise_cnt;
		upd_snap = upd_cnt;
		sample_snap = sample_cnt;
		repeat (60)
		begin
			@(negedge clk);
			if (sdio_clk !== 1'b0)
				report_mismatch("sdio_clk while stopped", sdio_clk, 0);
		end
		check_cnt++;
		if (rise_cnt != rise_snap)
			report_mismatch("sdio_clk rises while stopped", rise_cnt - rise_snap, 0);
		if (upd_cnt != upd_snap || sample_cnt != sample_snap)
			report_mismatch("strobes while stopped",
				(upd_cnt - upd_snap) + (sample_cnt - sample_snap), 0);
		@(posedge clk);
		div_rate <= 10'd6;
		@(posedge clk);
		en_sdio_clk <= 1'b1;
		check_periods(6, 1, 4); // first rise ends no full period
		end_run;
	end

endmodule

`default_nettype wire

// File: tb.f
sdio_pkg.sv
sdio_cmd_if.sv
sdio_resp_if.sv
sdio_sck_generator.sv
sdio_crc7.sv
sdio_cmd_tx.sv
sdio_resp_rx.sv
sdio_cmd_ctrl.sv
sdio_host_top.sv
tb_sdio_card.sv
tb_sdio_host.sv
